// File: include/fsab_mem_cfg.svh
`ifndef FSAB_MEM_CFG_SVH
`define FSAB_MEM_CFG_SVH

// FSAB bus geometry
`define FSAB_DATA_W 64
`define FSAB_MASK_W 8
`define FSAB_ADDR_W 31
`define FSAB_DID_W 4
`define FSAB_LEN_W 4
`define FSAB_LEN_MAX 8

// Request credits also reused for responses
`define FSAB_INITIAL_CREDITS 4

// On-chip RAM of 128-bit words
`define MEM_ADDR_W 6

`endif

// File: hdl/fsab_mem_pkg.sv
`default_nettype none
`include "fsab_mem_cfg.svh"

package fsab_mem_pkg;

	typedef enum logic {
		FSAB_READ  = 1'b0,
		FSAB_WRITE = 1'b1
	} fsab_mode_e;

	typedef struct packed {
		fsab_mode_e               mode;
		logic [`FSAB_DID_W-1:0]  did;
		logic [`FSAB_DID_W-1:0]  subdid;
		logic [`FSAB_ADDR_W-1:0] addr;    // Byte address on a 16-byte boundary
		logic [`FSAB_LEN_W-1:0]  len;     // Beats
	} fsab_req_t;

	// Two beats packed for one RAM word
	typedef struct packed {
		logic [`FSAB_DATA_W-1:0] hi_data;
		logic [`FSAB_MASK_W-1:0] hi_mask;
		logic [`FSAB_DATA_W-1:0] lo_data; // Earlier beat
		logic [`FSAB_MASK_W-1:0] lo_mask;
	} wdata_pair_t;

	typedef struct packed {
		logic [`FSAB_DID_W-1:0] did;
		logic [`FSAB_DID_W-1:0] subdid;
		logic [`FSAB_LEN_W-1:0] len;
	} resp_hdr_t;

	typedef struct packed {
		logic [`FSAB_DATA_W-1:0] hi;
		logic [`FSAB_DATA_W-1:0] lo;      // Lower address
	} mem_word_t;

endpackage

`default_nettype wire

// File: hdl/fsab_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module fsab_fifo #(
	parameter int  DEPTH     = 4,
	parameter type payload_t = logic [7:0]
) (
	input  wire           clk0_tb,
	input  wire           rst0_tb,
	input  wire           wr_en,
	input  wire payload_t wr_data,
	input  wire           rd_en,
	output payload_t      rd_data,
	output logic          empty
);
	localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CW = $clog2(DEPTH + 1);

	payload_t      mem [DEPTH];
	logic [AW-1:0] wr_ptr;
	logic [AW-1:0] rd_ptr;
	logic [CW-1:0] count;

	assign empty = (count == 0);

	always_ff @(posedge clk0_tb or posedge rst0_tb) begin
		if (rst0_tb) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (wr_en)
				wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (rd_en)
				rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			count <= count + CW'(wr_en) - CW'(rd_en);
		end
	end

	always_ff @(posedge clk0_tb) begin
		if (wr_en)
			mem[wr_ptr] <= wr_data;
		if (rd_en)
			rd_data <= mem[rd_ptr]; // Valid the cycle after the pop
	end

endmodule

`default_nettype wire

// File: hdl/fsab_ingress.sv
`timescale 1ns/1ps
`default_nettype none
`include "fsab_mem_cfg.svh"

module fsab_ingress import fsab_mem_pkg::*; (
	input  wire                    clk0_tb,
	input  wire                    rst0_tb,
	input  wire                    fsabo_valid,
	input  wire fsab_mode_e        fsabo_mode,
	input  wire [`FSAB_DID_W-1:0]  fsabo_did,
	input  wire [`FSAB_DID_W-1:0]  fsabo_subdid,
	input  wire [`FSAB_ADDR_W-1:0] fsabo_addr,
	input  wire [`FSAB_LEN_W-1:0]  fsabo_len,
	input  wire [`FSAB_DATA_W-1:0] fsabo_data,
	input  wire [`FSAB_MASK_W-1:0] fsabo_mask,
	output logic                   req_wr,
	output fsab_req_t              req_data,
	output logic                   pair_wr,
	output wdata_pair_t            pair_data
);
	logic [`FSAB_LEN_W-1:0]  beats_left;   // Write beats still to come
	logic                    have_prev;
	fsab_req_t               held_req;
	logic [`FSAB_DATA_W-1:0] prev_data;
	logic [`FSAB_MASK_W-1:0] prev_mask;
	logic                    new_req;
	logic                    write_beat;
	logic                    last_beat;

	assign new_req    = fsabo_valid && (beats_left == 0);
	assign write_beat = fsabo_valid && ((beats_left != 0) || (fsabo_mode == FSAB_WRITE));
	assign last_beat  = new_req ? (fsabo_len == 1) : (beats_left == 1);

	// A write request goes in with its last pair, so its data is always queued first
	assign pair_wr = write_beat && (have_prev || last_beat);
	assign req_wr  = (new_req && (fsabo_mode == FSAB_READ)) || (write_beat && last_beat);

	always_comb begin
		if (new_req) begin
			req_data.mode   = fsabo_mode;
			req_data.did    = fsabo_did;
			req_data.subdid = fsabo_subdid;
			req_data.addr   = fsabo_addr;
			req_data.len    = fsabo_len;
		end else begin
			req_data = held_req;
		end
	end

	always_comb begin
		if (have_prev) begin
			pair_data.hi_data = fsabo_data;
			pair_data.hi_mask = fsabo_mask;
			pair_data.lo_data = prev_data;
			pair_data.lo_mask = prev_mask;
		end else begin
			pair_data.hi_data = '0;        // Odd tail leaves the upper half untouched
			pair_data.hi_mask = '0;
			pair_data.lo_data = fsabo_data;
			pair_data.lo_mask = fsabo_mask;
		end
	end

	always_ff @(posedge clk0_tb or posedge rst0_tb) begin
		if (rst0_tb) begin
			beats_left <= '0;
			have_prev  <= 1'b0;
		end else begin
			if (new_req && (fsabo_mode == FSAB_WRITE))
				beats_left <= fsabo_len - 1'b1;
			else if (fsabo_valid && (beats_left != 0))
				beats_left <= beats_left - 1'b1;
			if (write_beat)
				have_prev <= !have_prev && !last_beat;
		end
	end

	always_ff @(posedge clk0_tb) begin
		if (new_req)
			held_req <= req_data;
		if (write_beat) begin
			prev_data <= fsabo_data;
			prev_mask <= fsabo_mask;
		end
	end

endmodule

`default_nettype wire

// File: hdl/mem_sequencer.sv
`timescale 1ns/1ps
`default_nettype none
`include "fsab_mem_cfg.svh"

module mem_sequencer import fsab_mem_pkg::*; (
	input  wire                     clk0_tb,
	input  wire                     rst0_tb,
	input  wire                     req_empty,
	input  wire fsab_req_t          req_q,
	input  wire wdata_pair_t        pair_q,
	input  wire                     resp_done,
	output logic                    req_rd,
	output logic                    pair_rd,
	output logic                    mem_we,
	output logic                    mem_re,
	output logic [`MEM_ADDR_W-1:0]  mem_idx,
	output mem_word_t               mem_wword,
	output logic [15:0]             mem_wmask,
	output logic                    hdr_wr,
	output resp_hdr_t               hdr_data,
	output logic                    fsabo_credit
);
	localparam int CRW = $clog2(`FSAB_INITIAL_CREDITS + 1);

	typedef enum logic [2:0] {S_IDLE, S_HDR, S_WRITE, S_RWAIT, S_READ} state_e;

	state_e                 state;
	logic [`FSAB_LEN_W-1:0] words_left;
	logic [`MEM_ADDR_W-1:0] word_idx;
	logic [CRW-1:0]         resp_credits;
	logic                   last_word;
	logic                   debit;

	assign last_word = (words_left == 1);
	assign req_rd    = (state == S_IDLE) && !req_empty;
	assign pair_rd   = ((state == S_HDR) && (req_q.mode == FSAB_WRITE)) ||
	                   ((state == S_WRITE) && !last_word);
	assign mem_we    = (state == S_WRITE);  // Pair popped last cycle
	assign mem_re    = (state == S_READ);
	assign mem_idx   = word_idx;
	assign mem_wword = '{hi: pair_q.hi_data, lo: pair_q.lo_data};
	assign mem_wmask = {pair_q.hi_mask, pair_q.lo_mask};

	// Response space is reserved before any read is issued
	assign debit    = (state == S_RWAIT) && (resp_credits != 0);
	assign hdr_wr   = debit;
	assign hdr_data = '{did: req_q.did, subdid: req_q.subdid, len: req_q.len};

	assign fsabo_credit = (mem_we || mem_re) && last_word;

	always_ff @(posedge clk0_tb or posedge rst0_tb) begin
		if (rst0_tb) begin
			state      <= S_IDLE;
			words_left <= '0;
			word_idx   <= '0;
		end else begin
			case (state)
				S_IDLE: begin
					if (req_rd)
						state <= S_HDR;
				end
				S_HDR: begin
					words_left <= {1'b0, req_q.len[`FSAB_LEN_W-1:1]} + req_q.len[0];
					word_idx   <= req_q.addr[4 +: `MEM_ADDR_W]; // 16 bytes per word
					state      <= (req_q.mode == FSAB_WRITE) ? S_WRITE : S_RWAIT;
				end
				S_RWAIT: begin
					if (debit)
						state <= S_READ;
				end
				S_WRITE, S_READ: begin
					words_left <= words_left - 1'b1;
					word_idx   <= word_idx + 1'b1;
					if (last_word)
						state <= S_IDLE;
				end
				default: state <= S_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk0_tb or posedge rst0_tb) begin
		if (rst0_tb)
			resp_credits <= CRW'(`FSAB_INITIAL_CREDITS);
		else
			resp_credits <= resp_credits - CRW'(debit) + CRW'(resp_done);
	end

endmodule

`default_nettype wire

// File: hdl/ram_backend.sv
`timescale 1ns/1ps
`default_nettype none
`include "fsab_mem_cfg.svh"

module ram_backend import fsab_mem_pkg::*; (
	input  wire                    clk0_tb,
	input  wire                    rst0_tb,
	input  wire                    mem_we,
	input  wire                    mem_re,
	input  wire [`MEM_ADDR_W-1:0]  mem_idx,
	input  wire mem_word_t         mem_wword,
	input  wire [15:0]             mem_wmask,
	output logic                   rd_valid,
	output mem_word_t              rd_word
);
	localparam int WORDS = 1 << `MEM_ADDR_W;
	localparam int BYTES = $bits(mem_word_t) / 8;

	mem_word_t mem [WORDS];

	always_ff @(posedge clk0_tb) begin
		if (mem_we) begin
			for (int b = 0; b < BYTES; b++) begin
				if (mem_wmask[b])
					mem[mem_idx][8*b +: 8] <= mem_wword[8*b +: 8]; // Byte lane enable
			end
		end
		if (mem_re)
			rd_word <= mem[mem_idx];
	end

	always_ff @(posedge clk0_tb or posedge rst0_tb) begin
		if (rst0_tb)
			rd_valid <= 1'b0;
		else
			rd_valid <= mem_re;  // One cycle read return
	end

endmodule

`default_nettype wire

// File: hdl/fsab_egress.sv
`timescale 1ns/1ps
`default_nettype none
`include "fsab_mem_cfg.svh"

module fsab_egress import fsab_mem_pkg::*; (
	input  wire                     clk0_tb,
	input  wire                     rst0_tb,
	input  wire                     hdr_empty,
	input  wire resp_hdr_t          hdr_q,
	input  wire                     word_empty,
	input  wire mem_word_t          word_q,
	output logic                    hdr_rd,
	output logic                    word_rd,
	output logic                    resp_done,
	output logic                    fsabi_valid,
	output logic [`FSAB_DID_W-1:0]  fsabi_did,
	output logic [`FSAB_DID_W-1:0]  fsabi_subdid,
	output logic [`FSAB_DATA_W-1:0] fsabi_data
);
	logic [`FSAB_LEN_W-1:0] beats_left;
	logic [`FSAB_LEN_W-1:0] cur_left;
	logic                   started;    // First beat right after the header pop
	logic                   upper;
	logic                   upper_sel;
	logic                   busy;
	logic                   last_beat;
	logic                   pop_new;

	assign busy      = started || (beats_left != 0);
	assign cur_left  = started ? hdr_q.len : beats_left;
	assign upper_sel = !started && upper;
	assign last_beat = busy && (cur_left == 1);
	assign pop_new   = !busy && !hdr_empty && !word_empty;

	assign hdr_rd  = pop_new;
	// Next word is fetched while its predecessor's upper half goes out
	assign word_rd = pop_new || (busy && upper_sel && !last_beat);

	assign resp_done    = last_beat;
	assign fsabi_valid  = busy;
	assign fsabi_did    = hdr_q.did;
	assign fsabi_subdid = hdr_q.subdid;
	assign fsabi_data   = upper_sel ? word_q.hi : word_q.lo;

	always_ff @(posedge clk0_tb or posedge rst0_tb) begin
		if (rst0_tb) begin
			started    <= 1'b0;
			beats_left <= '0;
			upper      <= 1'b0;
		end else begin
			started <= pop_new;
			if (busy) begin
				beats_left <= cur_left - 1'b1;
				upper      <= !upper_sel;
			end
		end
	end

endmodule

`default_nettype wire

// File: hdl/fsab_mem_top.sv
`timescale 1ns/1ps
`default_nettype none
`include "fsab_mem_cfg.svh"

module fsab_mem_top import fsab_mem_pkg::*; (
	input  wire                     clk0_tb,
	input  wire                     rst0_tb,
	input  wire                     fsabo_valid,
	input  wire fsab_mode_e         fsabo_mode,
	input  wire [`FSAB_DID_W-1:0]   fsabo_did,
	input  wire [`FSAB_DID_W-1:0]   fsabo_subdid,
	input  wire [`FSAB_ADDR_W-1:0]  fsabo_addr,
	input  wire [`FSAB_LEN_W-1:0]   fsabo_len,
	input  wire [`FSAB_DATA_W-1:0]  fsabo_data,
	input  wire [`FSAB_MASK_W-1:0]  fsabo_mask,
	output logic                    fsabo_credit,
	output logic                    fsabi_valid,
	output logic [`FSAB_DID_W-1:0]  fsabi_did,
	output logic [`FSAB_DID_W-1:0]  fsabi_subdid,
	output logic [`FSAB_DATA_W-1:0] fsabi_data
);
	localparam int REQ_DEPTH  = `FSAB_INITIAL_CREDITS;
	localparam int WORD_DEPTH = `FSAB_INITIAL_CREDITS * `FSAB_LEN_MAX / 2;

	logic                   req_wr;
	logic                   req_rd;
	logic                   req_empty;
	fsab_req_t              req_in;
	fsab_req_t              req_q;
	logic                   pair_wr;
	logic                   pair_rd;
	wdata_pair_t            pair_in;
	wdata_pair_t            pair_q;
	logic                   mem_we;
	logic                   mem_re;
	logic [`MEM_ADDR_W-1:0] mem_idx;
	mem_word_t              mem_wword;
	logic [15:0]            mem_wmask;
	logic                   rd_valid;
	mem_word_t              rd_word;
	logic                   hdr_wr;
	logic                   hdr_rd;
	logic                   hdr_empty;
	resp_hdr_t              hdr_in;
	resp_hdr_t              hdr_q;
	logic                   word_rd;
	logic                   word_empty;
	mem_word_t              word_q;
	logic                   resp_done;

	fsab_ingress u_ingress (
		.clk0_tb      (clk0_tb),
		.rst0_tb      (rst0_tb),
		.fsabo_valid  (fsabo_valid),
		.fsabo_mode   (fsabo_mode),
		.fsabo_did    (fsabo_did),
		.fsabo_subdid (fsabo_subdid),
		.fsabo_addr   (fsabo_addr),
		.fsabo_len    (fsabo_len),
		.fsabo_data   (fsabo_data),
		.fsabo_mask   (fsabo_mask),
		.req_wr       (req_wr),
		.req_data     (req_in),
		.pair_wr      (pair_wr),
		.pair_data    (pair_in)
	);

	fsab_fifo #(.DEPTH(REQ_DEPTH), .payload_t(fsab_req_t)) u_req_fifo (
		.clk0_tb (clk0_tb),
		.rst0_tb (rst0_tb),
		.wr_en   (req_wr),
		.wr_data (req_in),
		.rd_en   (req_rd),
		.rd_data (req_q),
		.empty   (req_empty)
	);

	// Pairs always lead their request, so this empty flag is never consulted
	fsab_fifo #(.DEPTH(WORD_DEPTH), .payload_t(wdata_pair_t)) u_pair_fifo (
		.clk0_tb (clk0_tb),
		.rst0_tb (rst0_tb),
		.wr_en   (pair_wr),
		.wr_data (pair_in),
		.rd_en   (pair_rd),
		.rd_data (pair_q),
		.empty   ()
	);

	mem_sequencer u_seq (
		.clk0_tb      (clk0_tb),
		.rst0_tb      (rst0_tb),
		.req_empty    (req_empty),
		.req_q        (req_q),
		.pair_q       (pair_q),
		.resp_done    (resp_done),
		.req_rd       (req_rd),
		.pair_rd      (pair_rd),
		.mem_we       (mem_we),
		.mem_re       (mem_re),
		.mem_idx      (mem_idx),
		.mem_wword    (mem_wword),
		.mem_wmask    (mem_wmask),
		.hdr_wr       (hdr_wr),
		.hdr_data     (hdr_in),
		.fsabo_credit (fsabo_credit)
	);

	ram_backend u_ram (
		.clk0_tb   (clk0_tb),
		.rst0_tb   (rst0_tb),
		.mem_we    (mem_we),
		.mem_re    (mem_re),
		.mem_idx   (mem_idx),
		.mem_wword (mem_wword),
		.mem_wmask (mem_wmask),
		.rd_valid  (rd_valid),
		.rd_word   (rd_word)
	);

	fsab_fifo #(.DEPTH(REQ_DEPTH), .payload_t(resp_hdr_t)) u_hdr_fifo (
		.clk0_tb (clk0_tb),
		.rst0_tb (rst0_tb),
		.wr_en   (hdr_wr),
		.wr_data (hdr_in),
		.rd_en   (hdr_rd),
		.rd_data (hdr_q),
		.empty   (hdr_empty)
	);

	fsab_fifo #(.DEPTH(WORD_DEPTH), .payload_t(mem_word_t)) u_word_fifo (
		.clk0_tb (clk0_tb),
		.rst0_tb (rst0_tb),
		.wr_en   (rd_valid),
		.wr_data (rd_word),
		.rd_en   (word_rd),
		.rd_data (word_q),
		.empty   (word_empty)
	);

	fsab_egress u_egress (
		.clk0_tb      (clk0_tb),
		.rst0_tb      (rst0_tb),
		.hdr_empty    (hdr_empty),
		.hdr_q        (hdr_q),
		.word_empty   (word_empty),
		.word_q       (word_q),
		.hdr_rd       (hdr_rd),
		.word_rd      (word_rd),
		.resp_done    (resp_done),
		.fsabi_valid  (fsabi_valid),
		.fsabi_did    (fsabi_did),
		.fsabi_subdid (fsabi_subdid),
		.fsabi_data   (fsabi_data)
	);

endmodule

`default_nettype wire

// File: tb/tb_fsab_mem.sv
`timescale 1ns/1ps
`default_nettype none
`include "fsab_mem_cfg.svh"

module tb_fsab_mem import fsab_mem_pkg::*; ();
	localparam int NUM_TESTS       = 13;
	localparam int RESET_CYCLES    = 16;
	localparam int CYCLES_PER_TEST = 40;
	localparam int TIMEOUT_CYCLES  = RESET_CYCLES + CYCLES_PER_TEST * NUM_TESTS;
	localparam int MODEL_BYTES     = 16 << `MEM_ADDR_W;

	// Stimulus table with one entry per request
	string t_name [NUM_TESTS] = '{
		"fill_lo", "fill_hi", "full_read", "masked_write", "masked_read",
		"odd_write", "odd_read", "multi_rd0", "multi_rd1", "multi_rd2",
		"multi_rd3", "single_write", "single_read"};
	localparam fsab_mode_e T_MODE [NUM_TESTS] = '{
		FSAB_WRITE, FSAB_WRITE, FSAB_READ, FSAB_WRITE, FSAB_READ,
		FSAB_WRITE, FSAB_READ, FSAB_READ, FSAB_READ, FSAB_READ,
		FSAB_READ, FSAB_WRITE, FSAB_READ};
	localparam logic [`FSAB_DID_W-1:0] T_DID [NUM_TESTS] = '{
		4'h1, 4'h1, 4'h3, 4'h2, 4'h6, 4'h4, 4'h7, 4'h8, 4'h9, 4'ha, 4'hb, 4'h5, 4'hc};
	localparam logic [`FSAB_DID_W-1:0] T_SUBDID [NUM_TESTS] = '{
		4'h0, 4'h1, 4'h5, 4'h2, 4'h1, 4'h3, 4'h2, 4'h1, 4'h2, 4'h3, 4'h4, 4'h6, 4'h7};
	localparam logic [`FSAB_ADDR_W-1:0] T_ADDR [NUM_TESTS] = '{
		31'h000, 31'h040, 31'h000, 31'h000, 31'h000, 31'h040, 31'h040,
		31'h000, 31'h010, 31'h040, 31'h070, 31'h030, 31'h020};
	localparam logic [`FSAB_LEN_W-1:0] T_LEN [NUM_TESTS] = '{
		4'd8, 4'd8, 4'd8, 4'd8, 4'd8, 4'd3, 4'd4, 4'd8, 4'd4, 4'd6, 4'd1, 4'd1, 4'd4};
	localparam logic [`FSAB_MASK_W-1:0] T_MASK [NUM_TESTS] = '{
		8'hff, 8'hff, 8'h00, 8'ha5, 8'h00, 8'hff, 8'h00,
		8'h00, 8'h00, 8'h00, 8'h00, 8'h3c, 8'h00};

	logic                    clk0_tb = 1'b0;
	logic                    rst0_tb;
	logic                    fsabo_valid;
	fsab_mode_e              fsabo_mode;
	logic [`FSAB_DID_W-1:0]  fsabo_did;
	logic [`FSAB_DID_W-1:0]  fsabo_subdid;
	logic [`FSAB_ADDR_W-1:0] fsabo_addr;
	logic [`FSAB_LEN_W-1:0]  fsabo_len;
	logic [`FSAB_DATA_W-1:0] fsabo_data;
	logic [`FSAB_MASK_W-1:0] fsabo_mask;
	logic                    fsabo_credit;
	logic                    fsabi_valid;
	logic [`FSAB_DID_W-1:0]  fsabi_did;
	logic [`FSAB_DID_W-1:0]  fsabi_subdid;
	logic [`FSAB_DATA_W-1:0] fsabi_data;

	logic [7:0]  model [MODEL_BYTES];  // Byte image of the RAM
	logic [31:0] lfsr_state;
	logic [63:0] exp_beat;
	logic [63:0] exp_beats [$];        // Read data owed in order
	int          resp_q [$];           // Table index per read response
	int          credit_q [$];         // Table index per request issued
	int          test_errs [NUM_TESTS];
	int          issued;
	int          credits;
	int          cycle_count;
	int          error_count;
	int          idle_errs;
	int          tests_ok;
	int          tests_bad;
	int          done_t;
	int          resp_test;
	int          resp_beat;
	logic        resp_active;

	fsab_mem_top dut0 (
		.clk0_tb      (clk0_tb),
		.rst0_tb      (rst0_tb),
		.fsabo_valid  (fsabo_valid),
		.fsabo_mode   (fsabo_mode),
		.fsabo_did    (fsabo_did),
		.fsabo_subdid (fsabo_subdid),
		.fsabo_addr   (fsabo_addr),
		.fsabo_len    (fsabo_len),
		.fsabo_data   (fsabo_data),
		.fsabo_mask   (fsabo_mask),
		.fsabo_credit (fsabo_credit),
		.fsabi_valid  (fsabi_valid),
		.fsabi_did    (fsabi_did),
		.fsabi_subdid (fsabi_subdid),
		.fsabi_data   (fsabi_data)
	);

	always #50 clk0_tb = ~clk0_tb;  // 100 ns period

	// Taps 32, 22, 2, 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic draw_beat(output logic [63:0] d);
		d = '0;
		for (int i = 0; i < 64; i++) begin
			lfsr_state = lfsr_next(lfsr_state);
			d = {d[62:0], lfsr_state[0]};  // One step per bit
		end
	endtask

	function automatic logic [7:0] beat_mask(input logic [7:0] m, input int k);
		logic [15:0] w;
		w = {m, m} << (k % 8);  // Rotate left by beat number
		return w[15:8];
	endfunction

	function automatic logic [63:0] model_beat(input int a);
		logic [63:0] d;
		for (int b = 0; b < 8; b++)
			d[8*b +: 8] = model[a + b];
		return d;
	endfunction

	task automatic report_mismatch(input int t, input string what, input logic [63:0] exp_v,
			input logic [63:0] act_v);
		$display("[FAIL] %s %s: expected %0h, actual %0h", t_name[t], what, exp_v, act_v);
		test_errs[t]++;
		error_count++;
	endtask

	task automatic report_error(input string msg);
		$display("ERROR: %s", msg);
		error_count++;
	endtask

	task automatic finish_test(input string name, input int errs);
		if (errs == 0) begin
			tests_ok++;
			$display("[DONE] %s: ok", name);
		end else begin
			tests_bad++;
			$display("[DONE] %s: %0d errors", name, errs);
		end
	endtask

	task automatic send_request(input int t);
		logic [63:0] beat;
		logic [7:0]  m;
		int          base;
		int          nbeats;
		base   = int'(T_ADDR[t]);
		nbeats = (T_MODE[t] == FSAB_WRITE) ? int'(T_LEN[t]) : 1;
		while (issued - credits >= `FSAB_INITIAL_CREDITS) begin
			fsabo_valid = 1'b0;  // Out of credits
			@(negedge clk0_tb);
		end
		if (T_MODE[t] == FSAB_READ) begin
			for (int k = 0; k < int'(T_LEN[t]); k++)
				exp_beats.push_back(model_beat(base + 8 * k));
			resp_q.push_back(t);
		end
		credit_q.push_back(t);
		issued++;
		for (int k = 0; k < nbeats; k++) begin
			beat = '0;
			m    = '0;
			if (T_MODE[t] == FSAB_WRITE) begin
				draw_beat(beat);
				m = beat_mask(T_MASK[t], k);
				for (int b = 0; b < 8; b++) begin
					if (m[b])
						model[base + 8 * k + b] = beat[8*b +: 8];
				end
			end
			fsabo_valid  = 1'b1;
			fsabo_mode   = T_MODE[t];
			fsabo_did    = T_DID[t];
			fsabo_subdid = T_SUBDID[t];
			fsabo_addr   = T_ADDR[t];
			fsabo_len    = T_LEN[t];
			fsabo_data   = beat;
			fsabo_mask   = m;
			@(negedge clk0_tb);
		end
	endtask

	// Response and credit monitor
	always @(posedge clk0_tb) begin
		if (!rst0_tb) begin
			if (issued == 0) begin
				assert (fsabi_valid === 1'b0 && fsabo_credit === 1'b0) else begin
					idle_errs++;
					report_error("bus active after reset before any request");
				end
			end
			if (fsabo_credit === 1'b1) begin
				credits++;
				assert (credit_q.size() != 0) else
					report_error("fsabo_credit pulsed with no request outstanding");
				if (credit_q.size() != 0) begin
					done_t = credit_q.pop_front();
					if (T_MODE[done_t] == FSAB_WRITE)
						finish_test(t_name[done_t], test_errs[done_t]);
				end
			end
			if (fsabi_valid === 1'b1) begin
				if (!resp_active) begin
					assert (resp_q.size() != 0) else
						report_error("fsabi_valid with no read response owed");
					if (resp_q.size() != 0) begin
						resp_test   = resp_q.pop_front();
						resp_beat   = 0;
						resp_active = 1'b1;
					end
				end
				if (resp_active) begin
					exp_beat = exp_beats.pop_front();
					assert (fsabi_did === T_DID[resp_test]) else
						report_mismatch(resp_test, "did", 64'(T_DID[resp_test]), 64'(fsabi_did));
					assert (fsabi_subdid === T_SUBDID[resp_test]) else
						report_mismatch(resp_test, "subdid", 64'(T_SUBDID[resp_test]),
							64'(fsabi_subdid));
					assert (fsabi_data === exp_beat) else
						report_mismatch(resp_test, $sformatf("beat %0d", resp_beat), exp_beat,
							fsabi_data);
					resp_beat++;
					if (resp_beat == int'(T_LEN[resp_test])) begin
						resp_active = 1'b0;
						finish_test(t_name[resp_test], test_errs[resp_test]);
					end
				end
			end else begin
				assert (!resp_active) else begin
					test_errs[resp_test]++;
					report_error($sformatf("gap in the response of %s", t_name[resp_test]));
				end
			end
		end
	end

	always @(posedge clk0_tb) begin
		cycle_count++;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("Timeout after %0d cycles, %0d of %0d credits back, %0d responses owed",
				cycle_count, credits, issued, resp_q.size());
			$display("TEST FAILED");
			$finish;
		end
	end

	initial begin
		rst0_tb      = 1'b1;
		fsabo_valid  = 1'b0;
		fsabo_mode   = FSAB_READ;
		fsabo_did    = '0;
		fsabo_subdid = '0;
		fsabo_addr   = '0;
		fsabo_len    = '0;
		fsabo_data   = '0;
		fsabo_mask   = '0;
		lfsr_state   = 32'h16c9_f9d4;
		resp_active  = 1'b0;
		for (int t = 0; t < NUM_TESTS; t++)
			test_errs[t] = 0;
		repeat (RESET_CYCLES) @(negedge clk0_tb);
		rst0_tb = 1'b0;
		repeat (4) @(negedge clk0_tb);  // Quiet bus window after reset
		finish_test("reset_idle", idle_errs);
		for (int t = 0; t < NUM_TESTS; t++)
			send_request(t);
		fsabo_valid = 1'b0;
		while (credits < issued || resp_q.size() != 0 || resp_active)
			@(negedge clk0_tb);
		assert (credits == NUM_TESTS) else
			report_error($sformatf("%0d credit pulses for %0d requests", credits, NUM_TESTS));
		$display("Tests: %0d ok, %0d with errors, %0d failed checks",
			tests_ok, tests_bad, error_count);
		if (error_count == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: filelist.f
+incdir+include
hdl/fsab_mem_pkg.sv
hdl/fsab_fifo.sv
hdl/fsab_ingress.sv
hdl/mem_sequencer.sv
hdl/ram_backend.sv
hdl/fsab_egress.sv
hdl/fsab_mem_top.sv
tb/tb_fsab_mem.sv

// File: run.sh
#!/bin/sh
# Compile and run the FSAB memory bridge testbench with Verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert -Wno-fatal \
	-f filelist.f --top-module tb_fsab_mem --Mdir "$OBJ" -o sim_tb
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

"./$OBJ/sim_tb" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "TEST FAILED" "$LOG"; then
	exit 1
fi
exit 0
